/* filelist.f */
common/permutePkg.sv
verilog/syncFifo.sv
permuter/permuteNetwork.sv
permuter/botPermuter.sv
accum/coeffAccumulator.sv
verilog/permutePipelineTop.sv
sim/permutePipelineTb.sv

/* sim/permutePipelineTb.sv */
module permutePipelineTb import permutePkg::*; ();

    // well under 1000 cycles of traffic over all tests, so this leaves wide margin
    localparam int cycleLimit = 20000;
    localparam int expDepth = 256;

    // bits whose index has bits 6..4 all equal stay put under every ordering
    localparam logic [botWidth-1:0] fixedBits = {16'hFFFF, 96'h0, 16'hFFFF};

    logic clk;
    logic reset;
    logic [botWidth-1:0] top;
    logic [botWidth-1:0] bot;
    logic writeData;
    permMask validBotPermutes;
    logic batchDone;
    logic slowDownInput;
    logic grabResults;
    logic resultsAvailable;
    logic [sumWidth-1:0] pcoeffSum;
    logic [countWidth-1:0] pcoeffCount;

    integer seed = 94075;
    int cycleCount = 0;

    // expected results in batch order
    logic [sumWidth-1:0] expSumArr [0:expDepth-1];
    logic [countWidth-1:0] expCountArr [0:expDepth-1];
    int expWr = 0;
    int expRd = 0;
    logic [countWidth-1:0] curCount = '0;
    logic [sumWidth-1:0] curSum = '0;
    logic batchDoneSeen = 1'b0;
    logic sawSlowDown = 1'b0;

    logic popNow;
    logic [sumWidth-1:0] headSum;
    logic [countWidth-1:0] headCount;

    assign popNow = grabResults && resultsAvailable;
    assign headSum = expSumArr[expRd % expDepth];
    assign headCount = expCountArr[expRd % expDepth];

    permutePipelineTop dut0 (
        .clk(clk),
        .reset(reset),
        .top(top),
        .bot(bot),
        .writeData(writeData),
        .validBotPermutes(validBotPermutes),
        .batchDone(batchDone),
        .slowDownInput(slowDownInput),
        .grabResults(grabResults),
        .resultsAvailable(resultsAvailable),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    // truth table with the three high variables reordered by ordering k
    function automatic logic [botWidth-1:0] permuteRef(
        input logic [botWidth-1:0] src,
        input int k
    );
        logic [8:0] landing;
        logic [6:0] outIdx;
        logic [6:0] srcIdx;
        logic [botWidth-1:0] res;
        // source variable that lands at output positions 6, 5, 4
        case (k)
            0: landing = {3'd6, 3'd5, 3'd4};
            1: landing = {3'd6, 3'd4, 3'd5};
            2: landing = {3'd5, 3'd6, 3'd4};
            3: landing = {3'd5, 3'd4, 3'd6};
            4: landing = {3'd4, 3'd6, 3'd5};
            default: landing = {3'd4, 3'd5, 3'd6};
        endcase
        for (int o = 0; o < botWidth; o++) begin
            outIdx = 7'(o);
            srcIdx = outIdx;
            srcIdx[landing[8:6]] = outIdx[6];
            srcIdx[landing[5:3]] = outIdx[5];
            srcIdx[landing[2:0]] = outIdx[4];
            res[o] = src[srcIdx];
        end
        return res;
    endfunction

    function automatic logic [botWidth-1:0] randomBot();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // folds one entry into the open batch and closes it on batchDone
    task automatic modelEntry(input logic [botWidth-1:0] b, input permMask m, input logic d);
        logic [botWidth-1:0] p;
        for (int k = 0; k < permCount; k++) begin
            if (m[k]) begin
                p = permuteRef(b, k);
                if ((p & ~top) == '0) begin
                    curCount = curCount + 1'b1;
                    curSum = curSum + sumWidth'($countones(top & ~p));
                end
            end
        end
        if (d) begin
            expSumArr[expWr % expDepth] = curSum;
            expCountArr[expWr % expDepth] = curCount;
            expWr = expWr + 1;
            curCount = '0;
            curSum = '0;
        end
    endtask

    // one write strobe per entry, holding off while slowDownInput is high
    task automatic sendEntry(input logic [botWidth-1:0] b, input permMask m, input logic d);
        @(negedge clk);
        while (slowDownInput) begin
            sawSlowDown = 1'b1;
            @(posedge clk);
            writeData <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        bot <= b;
        validBotPermutes <= m;
        batchDone <= d;
        writeData <= 1'b1;
        modelEntry(b, m, d);
    endtask

    task automatic stopInput();
        @(posedge clk);
        writeData <= 1'b0;
    endtask

    task automatic waitResults();
        while (expRd != expWr) begin
            @(negedge clk);
        end
    endtask

    // mix of sparse, dense and ordering-invariant bots
    function automatic logic [botWidth-1:0] mixedBot();
        int pick;
        pick = $unsigned($random(seed)) % 3;
        if (pick == 0) begin
            return randomBot() & top & fixedBits;
        end else if (pick == 1) begin
            return randomBot() & randomBot() & randomBot() & randomBot();
        end
        return randomBot();
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            failRun("timeout: the run went past the cycle limit without finishing");
        end
        if (!reset && writeData && batchDone) begin
            batchDoneSeen <= 1'b1;
        end
        if (!reset && popNow) begin
            expRd <= expRd + 1;
        end
    end

    resetQuiet: assert property (@(posedge clk)
        (cycleCount != 0 && reset) |-> (!slowDownInput && !resultsAvailable))
        else failRun("slowDownInput or resultsAvailable high during reset");

    noEarlyResult: assert property (@(posedge clk) disable iff (reset)
        !batchDoneSeen |-> !resultsAvailable)
        else failRun("a result appeared before any batch end was written");

    noExtraResult: assert property (@(posedge clk) disable iff (reset)
        popNow |-> (expRd < expWr))
        else failRun("the DUT returned a result that no batch accounts for");

    popValue: assert property (@(posedge clk) disable iff (reset)
        (popNow && expRd < expWr) |-> (pcoeffSum == headSum && pcoeffCount == headCount))
        else failRun($sformatf("Fail at %0t: got sum %0d count %0d, expected sum %0d count %0d",
            $time, $sampled(pcoeffSum), $sampled(pcoeffCount),
            $sampled(headSum), $sampled(headCount)));

    initial begin
        reset <= 1'b1;
        top <= randomBot() | randomBot();
        bot <= '0;
        validBotPermutes <= '0;
        batchDone <= 1'b0;
        writeData <= 1'b0;
        grabResults <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        grabResults <= 1'b1;

        // single bot with all six orderings, each a subset of top
        sendEntry(randomBot() & top & fixedBits, 6'h3F, 1'b1);
        stopInput();
        waitResults();

        // random batches, zero-mask fillers and bare batch markers
        sendEntry('0, '0, 1'b1);
        for (int b = 0; b < 12; b++) begin
            repeat ($unsigned($random(seed)) % 5) begin
                sendEntry(mixedBot(), permMask'($random(seed)), 1'b0);
                if (($random(seed) & 3) == 0) begin
                    sendEntry(randomBot(), '0, 1'b0);
                end
            end
            if (($random(seed) & 3) == 0) begin
                sendEntry(randomBot(), '0, 1'b1);
            end else begin
                sendEntry(mixedBot(), permMask'($random(seed)), 1'b1);
            end
        end
        stopInput();
        waitResults();

        // results held back across 30 batches, then drained
        @(posedge clk);
        grabResults <= 1'b0;
        for (int b = 0; b < 30; b++) begin
            sendEntry(mixedBot(), 6'h3F, 1'b1);
        end
        stopInput();
        repeat (60) @(posedge clk);
        grabResults <= 1'b1;
        waitResults();

        // write burst until slowDownInput pushes back
        sawSlowDown = 1'b0;
        for (int n = 0; n < 40; n++) begin
            sendEntry(mixedBot(), 6'h3F, (n % 8 == 7) || (n == 39));
        end
        stopInput();
        waitResults();
        assert (sawSlowDown)
            else failRun("slowDownInput never rose during the write burst");

        repeat (20) @(posedge clk);
        @(negedge clk);
        if (expRd == expWr && !resultsAvailable) begin
            $display("Everything OK");
            $finish;
        end else begin
            failRun("results were left over or missing at the end of the run");
        end
    end

endmodule

/* verilog/permutePipelineTop.sv */
module permutePipelineTop import permutePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [botWidth-1:0] top,

    // input side
    input  logic [botWidth-1:0] bot,
    input  logic writeData,
    input  permMask validBotPermutes,
    input  logic batchDone,
    output logic slowDownInput,

    // output side
    input  logic grabResults,
    output logic resultsAvailable,
    output logic [sumWidth-1:0] pcoeffSum,
    output logic [countWidth-1:0] pcoeffCount
);

    botEntry newEntry;
    botEntry headEntry;
    logic inputWrite;
    logic inputEmpty;
    logic [inputDepthLog2:0] inputUsed;

    logic grab;
    logic permDone;
    logic permValid;
    logic lastOfBatch;
    logic [botWidth-1:0] permutedBot;

    logic resultValid;
    batchResult result;
    logic resultValidQ;
    batchResult resultQ;

    batchResult resultHead;
    logic resultEmpty;
    logic [resultDepthLog2:0] resultUsed;
    logic resultThrottlePre;
    logic resultThrottle;

    // entries with nothing to permute and no batch end are dropped
    assign inputWrite = writeData && ((validBotPermutes != '0) || batchDone);

    assign newEntry.bot = bot;
    assign newEntry.mask = validBotPermutes;
    assign newEntry.batchDone = batchDone;

    always_ff @(posedge clk) begin
        if (reset) begin
            slowDownInput <= 1'b0;
        end else begin
            slowDownInput <= (inputUsed > inputSlowThreshold);
        end
    end

    syncFifo #(
        .payloadT(botEntry),
        .depthLog2(inputDepthLog2)
    ) inputFifo (
        .clk(clk),
        .reset(reset),
        .writeEnable(inputWrite),
        .dataIn(newEntry),
        .readEnable(grab),
        .dataOut(headEntry),
        .empty(inputEmpty),
        .full(),
        .used(inputUsed)
    );

    assign grab = permDone && !inputEmpty && !resultThrottle;

    botPermuter permuter0 (
        .clk(clk),
        .reset(reset),
        .startBurst(grab),
        .entryIn(headEntry),
        .done(permDone),
        .permValid(permValid),
        .lastOfBatch(lastOfBatch),
        .permutedBot(permutedBot)
    );

    coeffAccumulator accum0 (
        .clk(clk),
        .reset(reset),
        .top(top),
        .permValid(permValid),
        .permutedBot(permutedBot),
        .lastOfBatch(lastOfBatch),
        .resultValid(resultValid),
        .result(result)
    );

    // two register stages on the throttle, bursts in flight still land
    always_ff @(posedge clk) begin
        if (reset) begin
            resultThrottlePre <= 1'b0;
            resultThrottle <= 1'b0;
        end else begin
            resultThrottlePre <= (resultUsed > resultSlowThreshold);
            resultThrottle <= resultThrottlePre;
        end
    end

    // extra slack between accumulator and results FIFO
    always_ff @(posedge clk) begin
        if (reset) begin
            resultValidQ <= 1'b0;
        end else begin
            resultValidQ <= resultValid;
        end
    end

    always_ff @(posedge clk) begin
        resultQ <= result;
    end

    syncFifo #(
        .payloadT(batchResult),
        .depthLog2(resultDepthLog2)
    ) resultFifo (
        .clk(clk),
        .reset(reset),
        .writeEnable(resultValidQ),
        .dataIn(resultQ),
        .readEnable(grabResults && resultsAvailable),
        .dataOut(resultHead),
        .empty(resultEmpty),
        .full(),
        .used(resultUsed)
    );

    assign resultsAvailable = !resultEmpty;
    assign pcoeffSum = resultHead.sum;
    assign pcoeffCount = resultHead.count;

endmodule

/* accum/coeffAccumulator.sv */
module coeffAccumulator import permutePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [botWidth-1:0] top,
    input  logic permValid,
    input  logic [botWidth-1:0] permutedBot,
    input  logic lastOfBatch,
    output logic resultValid,
    output batchResult result
);

    // stage 1 registers
    logic s1Valid;
    logic s1Last;
    logic s1Subset;
    logic [popWidth-1:0] s1Uncovered;

    // running totals for the open batch
    logic [countWidth-1:0] countTotal;
    logic [sumWidth-1:0] sumTotal;
    logic [countWidth-1:0] countNext;
    logic [sumWidth-1:0] sumNext;
    logic hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1Valid <= 1'b0;
            s1Last <= 1'b0;
        end else begin
            s1Valid <= permValid;
            s1Last <= lastOfBatch;
        end
    end

    // subset when the bot sets no bit outside top
    always_ff @(posedge clk) begin
        s1Subset <= ((permutedBot & ~top) == '0);
        s1Uncovered <= popWidth'($countones(top & ~permutedBot));
    end

    assign hit = s1Valid && s1Subset;
    assign countNext = countTotal + countWidth'(hit);
    assign sumNext = sumTotal + (hit ? sumWidth'(s1Uncovered) : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            countTotal <= '0;
            sumTotal <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= s1Last;
            // the closing bot is counted before the totals clear
            if (s1Last) begin
                countTotal <= '0;
                sumTotal <= '0;
            end else begin
                countTotal <= countNext;
                sumTotal <= sumNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        result.count <= countNext;
        result.sum <= sumNext;
    end

    // a counted bot inside a batch must leave a nonzero total behind
    countNoWrap: assert property (@(posedge clk) disable iff (reset)
        hit && !s1Last |=> countTotal != '0)
        else $error("subset count wrapped within a batch");

endmodule

/* permuter/botPermuter.sv */
module botPermuter import permutePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic startBurst,
    input  botEntry entryIn,
    output logic done,
    output logic permValid,
    output logic lastOfBatch,
    output logic [botWidth-1:0] permutedBot
);

    typedef enum logic {
        stateIdle,
        stateEmit
    } permState;

    permState state;

    logic [botWidth-1:0] heldBot;
    logic heldBatchDone;
    permMask maskLeft;
    permMask maskAfter;
    logic [selWidth-1:0] selectNow;
    logic lastEmit;

    // lowest remaining ordering goes out first
    always_comb begin
        selectNow = '0;
        for (int k = permCount - 1; k >= 0; k--) begin
            if (maskLeft[k]) begin
                selectNow = selWidth'(k);
            end
        end
    end

    assign maskAfter = maskLeft & ~(permMask'(1) << selectNow);

    // a zero mask still takes one cycle, for the batch marker
    assign lastEmit = (maskAfter == '0);

    // high in the final emit cycle too, so bursts chain back to back
    assign done = (state == stateIdle) || lastEmit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateIdle;
            maskLeft <= '0;
            permValid <= 1'b0;
            lastOfBatch <= 1'b0;
        end else begin
            // delayed one cycle to match the network register
            permValid <= (state == stateEmit) && (maskLeft != '0);
            lastOfBatch <= (state == stateEmit) && lastEmit && heldBatchDone;

            if (startBurst) begin
                state <= stateEmit;
                maskLeft <= entryIn.mask;
            end else if (state == stateEmit) begin
                maskLeft <= maskAfter;
                if (lastEmit) begin
                    state <= stateIdle;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startBurst) begin
            heldBot <= entryIn.bot;
            heldBatchDone <= entryIn.batchDone;
        end
    end

    permuteNetwork network0 (
        .clk(clk),
        .botIn(heldBot),
        .select(selectNow),
        .permutedBot(permutedBot)
    );

    // the grab logic in the top must wait for done
    startWhileDone: assert property (@(posedge clk) disable iff (reset)
        startBurst |-> done)
        else $error("burst started while permuter busy");

endmodule

/* permuter/permuteNetwork.sv */
module permuteNetwork import permutePkg::*; (
    input  logic clk,
    input  logic [botWidth-1:0] botIn,
    input  logic [selWidth-1:0] select,
    output logic [botWidth-1:0] permutedBot
);

    logic [botWidth-1:0] reordered;

    // each output bit is a six-way mux over source bits
    // only index bits 6..4 move, bits 3..0 pass straight through
    always_comb begin
        for (int outIndex = 0; outIndex < botWidth; outIndex++) begin
            reordered[outIndex] = botIn[permuteIndex(botIndexWidth'(outIndex), select)];
        end
    end

    always_ff @(posedge clk) begin
        permutedBot <= reordered;
    end

endmodule

/* verilog/syncFifo.sv */
module syncFifo #(
    parameter type payloadT = logic,
    parameter int depthLog2 = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic writeEnable,
    input  payloadT dataIn,
    input  logic readEnable,
    output payloadT dataOut,
    output logic empty,
    output logic full,
    output logic [depthLog2:0] used
);

    localparam int depth = 2 ** depthLog2;

    payloadT storage [depth];

    logic [depthLog2-1:0] writePtr;
    logic [depthLog2-1:0] readPtr;
    logic [depthLog2:0] usedCount;
    logic doWrite;
    logic doRead;

    assign doWrite = writeEnable && !full;
    assign doRead = readEnable && !empty;

    assign empty = (usedCount == '0);
    assign full = (usedCount == (depthLog2 + 1)'(depth));
    assign used = usedCount;

    // head entry stays visible while not empty
    assign dataOut = storage[readPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            storage[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            writePtr <= '0;
            readPtr <= '0;
            usedCount <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            case ({doWrite, doRead})
                2'b10: usedCount <= usedCount + 1'b1;
                2'b01: usedCount <= usedCount - 1'b1;
                default: usedCount <= usedCount;
            endcase
        end
    end

    noOverflow: assert property (@(posedge clk) disable iff (reset)
        writeEnable |-> !full)
        else $error("write into a full FIFO");

    noUnderflow: assert property (@(posedge clk) disable iff (reset)
        readEnable |-> !empty)
        else $error("read from an empty FIFO");

endmodule

/* common/permutePkg.sv */
package permutePkg;

    // truth table of a 7-variable function
    localparam int botWidth = 128;
    localparam int botIndexWidth = $clog2(botWidth);

    // orderings of the three highest variables
    localparam int permCount = 6;
    localparam int selWidth = 3;

    // per-batch result widths
    localparam int countWidth = 12;
    localparam int popWidth = 8;
    localparam int sumWidth = countWidth + popWidth;

    // FIFO depths and throttle thresholds
    localparam int inputDepthLog2 = 5;
    localparam int resultDepthLog2 = 4;
    localparam int inputSlowThreshold = 24;
    localparam int resultSlowThreshold = 12;

    typedef logic [permCount-1:0] permMask;

    typedef struct packed {
        logic [botWidth-1:0] bot;
        permMask mask;
        logic batchDone;
    } botEntry;

    typedef struct packed {
        logic [sumWidth-1:0] sum;
        logic [countWidth-1:0] count;
    } batchResult;

    // per ordering, the source variable landing at output bits 6, 5, 4
    // coded as offset above bit 4, so A = 2, B = 1, C = 0
    typedef logic [5:0] permCode;

    localparam permCode [permCount-1:0] permOrder = {
        6'b00_01_10,    // 5: CBA
        6'b00_10_01,    // 4: CAB
        6'b01_00_10,    // 3: BCA
        6'b01_10_00,    // 2: BAC
        6'b10_00_01,    // 1: ACB
        6'b10_01_00     // 0: ABC
    };

    // source index read for a given output index under ordering sel
    function automatic logic [botIndexWidth-1:0] permuteIndex(
        input logic [botIndexWidth-1:0] outIndex,
        input logic [selWidth-1:0] sel
    );
        permCode code;
        logic [botIndexWidth-1:0] srcIndex;
        // unused select codes fall back to identity
        code = (sel < permCount) ? permOrder[sel] : permOrder[0];
        srcIndex = outIndex;
        srcIndex[4 + code[5:4]] = outIndex[6];
        srcIndex[4 + code[3:2]] = outIndex[5];
        srcIndex[4 + code[1:0]] = outIndex[4];
        return srcIndex;
    endfunction

endpackage
